/* include/lq_defines.svh */
// load queue sizing and size-code constants, included by the package and every RTL file
`ifndef LQ_DEFINES_SVH
`define LQ_DEFINES_SVH

// queue geometry
`define LQ_DEPTH        8
`define LQ_ID_W         3   // log2 of depth

// payload widths
`define LQ_DATA_W       32
`define LQ_EXC_W        5   // fp exception flags nv/dz/of/uf/nx
`define LQ_OFS_W        4   // byte offset kept from the address phase
`define LQ_SZ_W         3

// load size codes, bit 2 marks the unsigned / boxed forms
`define LQ_SZ_BYTE      3'd0
`define LQ_SZ_HALF      3'd1
`define LQ_SZ_WORD      3'd2
`define LQ_SZ_BYTEU     3'd4
`define LQ_SZ_HALFU     3'd5
`define LQ_SZ_HALF_NAN  3'd6  // fp16 load, upper half boxed with ones

`endif

/* source/lq_pkg.sv */
// shared entry and port types for the load queue, imported by the RTL and the testbench
`include "lq_defines.svh"

package lq_pkg;

  // dispatch info written at allocation
  typedef struct packed {
    logic                 load;  // entry waits on a memory return
    logic [4:0]           rd;    // destination register
  } lq_info_s;

  // address-phase attributes of a load
  typedef struct packed {
    logic [`LQ_SZ_W-1:0]  sz;
    logic [`LQ_OFS_W-1:0] ofs;
  } lq_load_attr_s;

  // execute-side exception flags, padded to the attribute width
  typedef struct packed {
    logic [1:0]           pad;
    logic [`LQ_EXC_W-1:0] flags;
  } lq_exc_s;

  // entry metadata, the info load bit picks the member
  typedef union packed {
    lq_load_attr_s attr;
    lq_exc_s       exc;
  } lq_meta_u;

  typedef struct packed {
    logic                 valid;
    logic [`LQ_ID_W-1:0]  id;
    lq_load_attr_s        attr;
  } lq_addr_wr_s;

  typedef struct packed {
    logic                  valid;
    logic [`LQ_ID_W-1:0]   id;
    logic [`LQ_DATA_W-1:0] data;
    logic [`LQ_EXC_W-1:0]  exc;
  } lq_exec_wr_s;

  // memory return, cancel arrives late in the cycle
  typedef struct packed {
    logic                  valid;
    logic                  cancel;
    logic [`LQ_ID_W-1:0]   id;
    logic [`LQ_DATA_W-1:0] data;
  } lq_ret_s;

  typedef struct packed {
    lq_info_s              info;
    lq_meta_u              meta;
    logic [`LQ_DATA_W-1:0] data;
    logic                  data_vld;
  } lq_head_s;

endpackage

/* source/lq_ptr_ctrl.sv */
// write and read pointers of the load queue, giving next id, head id, full and empty
`timescale 1ns/10ps
`include "lq_defines.svh"

module lq_ptr_ctrl (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_alloc,
  input  logic                i_rden,
  output logic [`LQ_ID_W-1:0] o_wr_id,
  output logic [`LQ_ID_W-1:0] o_head_id,
  output logic                o_full,
  output logic                o_empty
);

  localparam int PTR_W = `LQ_ID_W + 1;  // extra wrap bit

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             idx_equal;
  logic             wrap_equal;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (i_alloc) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (i_rden) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
    end
  end

  assign idx_equal  = (wr_ptr_q[`LQ_ID_W-1:0] == rd_ptr_q[`LQ_ID_W-1:0]);
  assign wrap_equal = (wr_ptr_q[`LQ_ID_W] == rd_ptr_q[`LQ_ID_W]);

  // same index, the wrap bit tells a full lap from no entries at all
  assign o_empty   = idx_equal & wrap_equal;
  assign o_full    = idx_equal & ~wrap_equal;

  assign o_wr_id   = wr_ptr_q[`LQ_ID_W-1:0];
  assign o_head_id = rd_ptr_q[`LQ_ID_W-1:0];

endmodule

/* source/lq_entry_store.sv */
// per-entry storage of the load queue with its write ports and combinational head read
`timescale 1ns/10ps
`include "lq_defines.svh"

module lq_entry_store (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // dispatch
  input  logic                i_alloc,
  input  lq_pkg::lq_info_s    i_alloc_info,
  input  logic [`LQ_ID_W-1:0] i_wr_id,
  // address phase and execute result
  input  lq_pkg::lq_addr_wr_s i_addr_wr,
  input  lq_pkg::lq_exec_wr_s i_exec_wr,
  // aligned memory return
  input  logic                i_ret_commit,
  input  lq_pkg::lq_ret_s     i_ret_aligned,
  // retire
  input  logic                i_rden,
  input  logic [`LQ_ID_W-1:0] i_head_id,
  // attribute lookup for the aligner
  input  logic [`LQ_ID_W-1:0] i_ret_id,
  output lq_pkg::lq_meta_u    o_ret_meta,
  output lq_pkg::lq_head_s    o_head
);

  import lq_pkg::*;

  lq_info_s              info_q [`LQ_DEPTH];
  lq_meta_u              meta_q [`LQ_DEPTH];
  logic [`LQ_DATA_W-1:0] data_q [`LQ_DEPTH];
  logic [`LQ_DEPTH-1:0]  data_vld_q;
  logic [`LQ_DEPTH-1:0]  data_vld_d;

  lq_meta_u              addr_meta;  // meta as seen by a load
  lq_meta_u              exec_meta;  // meta as seen by a non-load

  always_comb begin
    addr_meta           = '0;
    addr_meta.attr      = i_addr_wr.attr;
    exec_meta           = '0;
    exec_meta.exc.flags = i_exec_wr.exc;
  end

  // payload writes, ports target distinct entries in normal use
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      info_q[i_wr_id] <= i_alloc_info;
    end
    if (i_addr_wr.valid) begin
      meta_q[i_addr_wr.id] <= addr_meta;  // size and offset only
    end
    if (i_exec_wr.valid) begin
      meta_q[i_exec_wr.id] <= exec_meta;
      data_q[i_exec_wr.id] <= i_exec_wr.data;
    end
    if (i_ret_commit) begin
      data_q[i_ret_aligned.id] <= i_ret_aligned.data;
    end
  end

  always_comb begin
    data_vld_d = data_vld_q;
    if (i_exec_wr.valid) begin
      data_vld_d[i_exec_wr.id] = 1'b1;
    end
    if (i_ret_commit) begin
      data_vld_d[i_ret_aligned.id] = 1'b1;
    end
    // clears take priority over sets
    if (i_alloc) begin
      data_vld_d[i_wr_id] = 1'b0;
    end
    if (i_rden) begin
      data_vld_d[i_head_id] = 1'b0;  // head leaves the queue
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      data_vld_q <= '0;
    end else begin
      data_vld_q <= data_vld_d;
    end
  end

  assign o_ret_meta = meta_q[i_ret_id];

  assign o_head = '{
    info:     info_q[i_head_id],
    meta:     meta_q[i_head_id],
    data:     data_q[i_head_id],
    data_vld: data_vld_q[i_head_id]
  };

endmodule

/* source/lq_load_align.sv */
// aligns a memory return by the entry's byte offset and extends it by the load size
`timescale 1ns/10ps
`include "lq_defines.svh"

module lq_load_align (
  input  lq_pkg::lq_ret_s     i_ret,
  input  lq_pkg::lq_meta_u    i_ret_meta,  // looked up with o_ret_id
  output lq_pkg::lq_ret_s     o_ret_aligned,
  output logic [`LQ_ID_W-1:0] o_ret_id
);

  import lq_pkg::*;

  lq_load_attr_s attr;
  logic [7:0]    byte_data;
  logic [15:0]   half_data;

  assign o_ret_id = i_ret.id;
  assign attr     = i_ret_meta.attr;

  // word-wide return, only the low offset bits pick the lane
  assign byte_data = i_ret.data[8*attr.ofs[1:0] +: 8];
  assign half_data = i_ret.data[16*attr.ofs[1] +: 16];

  always_comb begin
    o_ret_aligned = i_ret;  // valid, cancel and id pass through
    case (attr.sz)
      `LQ_SZ_BYTE: begin
        o_ret_aligned.data = {{24{byte_data[7]}}, byte_data};
      end
      `LQ_SZ_HALF: begin
        o_ret_aligned.data = {{16{half_data[15]}}, half_data};
      end
      `LQ_SZ_BYTEU: begin
        o_ret_aligned.data = {24'h0, byte_data};
      end
      `LQ_SZ_HALFU: begin
        o_ret_aligned.data = {16'h0, half_data};
      end
      `LQ_SZ_HALF_NAN: begin
        o_ret_aligned.data = {16'hffff, half_data};  // nan-boxed fp16
      end
      default: begin
        o_ret_aligned.data = i_ret.data;  // word
      end
    endcase
  end

endmodule

/* source/lq_head_select.sv */
// head-of-queue logic for return bypass, register forward, store commit and head read
`timescale 1ns/10ps
`include "lq_defines.svh"

module lq_head_select (
  input  logic                  i_bypass_disable,
  input  lq_pkg::lq_ret_s       i_ret_aligned,
  input  logic [`LQ_ID_W-1:0]   i_head_id,
  input  lq_pkg::lq_head_s      i_head,
  // write back into storage
  output logic                  o_ret_commit,
  // consumer read
  output logic                  o_data_ready,
  output logic [`LQ_DATA_W-1:0] o_rddata,
  output logic [`LQ_EXC_W-1:0]  o_rdexc,
  output lq_pkg::lq_info_s      o_rdinfo,
  // register file forward
  output logic                  o_fwd_vld,
  output logic [`LQ_ID_W-1:0]   o_fwd_id,
  output logic [`LQ_DATA_W-1:0] o_fwd_data
);

  logic head_hit;
  logic bypass;

  assign head_hit = i_ret_aligned.valid & (i_ret_aligned.id == i_head_id);

  // a bypassed return is consumed straight from the port and never stored
  assign bypass   = head_hit & ~i_ret_aligned.cancel & ~i_bypass_disable;

  assign o_ret_commit = i_ret_aligned.valid & ~i_ret_aligned.cancel & ~bypass;

  assign o_data_ready = i_head.data_vld | bypass;
  assign o_rdinfo     = i_head.info;
  assign o_rddata     = bypass ? i_ret_aligned.data : i_head.data;

  // loads carry attributes in meta, not flags
  always_comb begin
    if (bypass || i_head.info.load) begin
      o_rdexc = '0;
    end else begin
      o_rdexc = i_head.meta.exc.flags;
    end
  end

  // cancel is late, so it only gates the valid
  assign o_fwd_vld  = head_hit & ~i_ret_aligned.cancel;
  assign o_fwd_id   = i_head_id;
  assign o_fwd_data = i_ret_aligned.data;

endmodule

/* source/lq_top.sv */
// load queue top level, connects pointer control, storage, return alignment and head logic
`timescale 1ns/10ps
`include "lq_defines.svh"

module lq_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_bypass_disable,
  // dispatch
  input  logic                  i_alloc,
  input  lq_pkg::lq_info_s      i_alloc_info,
  output logic [`LQ_ID_W-1:0]   o_next_id,
  // entry writes
  input  lq_pkg::lq_addr_wr_s   i_addr_wr,
  input  lq_pkg::lq_exec_wr_s   i_exec_wr,
  input  lq_pkg::lq_ret_s       i_ret,
  // retire
  input  logic                  i_rden,
  output logic [`LQ_ID_W-1:0]   o_head_id,
  output logic                  o_data_ready,
  output logic [`LQ_DATA_W-1:0] o_rddata,
  output logic [`LQ_EXC_W-1:0]  o_rdexc,
  output lq_pkg::lq_info_s      o_rdinfo,
  // register file forward
  output logic                  o_fwd_vld,
  output logic [`LQ_ID_W-1:0]   o_fwd_id,
  output logic [`LQ_DATA_W-1:0] o_fwd_data,
  // occupancy
  output logic                  o_full,
  output logic                  o_empty
);

  import lq_pkg::*;

  lq_ret_s             ret_aligned;
  logic [`LQ_ID_W-1:0] ret_id;
  lq_meta_u            ret_meta;
  lq_head_s            head;
  logic                ret_commit;

  lq_ptr_ctrl u_ptr (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (i_alloc),
    .i_rden    (i_rden),
    .o_wr_id   (o_next_id),
    .o_head_id (o_head_id),
    .o_full    (o_full),
    .o_empty   (o_empty)
  );

  lq_load_align u_align (
    .i_ret         (i_ret),
    .i_ret_meta    (ret_meta),
    .o_ret_aligned (ret_aligned),
    .o_ret_id      (ret_id)
  );

  lq_head_select u_head (
    .i_bypass_disable (i_bypass_disable),
    .i_ret_aligned    (ret_aligned),
    .i_head_id        (o_head_id),
    .i_head           (head),
    .o_ret_commit     (ret_commit),
    .o_data_ready     (o_data_ready),
    .o_rddata         (o_rddata),
    .o_rdexc          (o_rdexc),
    .o_rdinfo         (o_rdinfo),
    .o_fwd_vld        (o_fwd_vld),
    .o_fwd_id         (o_fwd_id),
    .o_fwd_data       (o_fwd_data)
  );

  lq_entry_store u_store (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc       (i_alloc),
    .i_alloc_info  (i_alloc_info),
    .i_wr_id       (o_next_id),
    .i_addr_wr     (i_addr_wr),
    .i_exec_wr     (i_exec_wr),
    .i_ret_commit  (ret_commit),
    .i_ret_aligned (ret_aligned),
    .i_rden        (i_rden),
    .i_head_id     (o_head_id),
    .i_ret_id      (ret_id),
    .o_ret_meta    (ret_meta),
    .o_head        (head)
  );

endmodule

/* bench/lq_top_assert.sv */
// concurrent checks of the load queue usage rules, bound into every lq_top instance
`timescale 1ns/10ps

module lq_top_assert (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_alloc,
  input logic i_rden,
  input logic i_full,
  input logic i_empty,
  input logic i_fwd_vld
);

  // no back-pressure, so the outside has to honour full and empty
  no_alloc_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_full |-> !i_alloc) else $error("allocation while the queue is full");

  no_retire_when_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_empty |-> !i_rden) else $error("retire while the queue is empty");

  fwd_needs_entry: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fwd_vld |-> !i_empty) else $error("forward valid with an empty queue");

endmodule

bind lq_top lq_top_assert u_assert (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_alloc   (i_alloc),
  .i_rden    (i_rden),
  .i_full    (o_full),
  .i_empty   (o_empty),
  .i_fwd_vld (o_fwd_vld)
);

/* bench/tb_lq_top.sv */
// simulation top that runs lq_top on seeded random traffic against a queue model
`timescale 1ns/10ps
`include "lq_defines.svh"

module tb_lq_top;
  import lq_pkg::*;

  // expected state of one queue entry
  typedef struct packed {
    lq_info_s              info;
    logic                  ready;
    logic [`LQ_SZ_W-1:0]   sz;
    logic [`LQ_OFS_W-1:0]  ofs;
    logic [`LQ_DATA_W-1:0] data;
    logic [`LQ_EXC_W-1:0]  exc;
  } model_entry_s;

  localparam logic [2:0] sz_codes [6] = '{`LQ_SZ_BYTE, `LQ_SZ_HALF, `LQ_SZ_WORD,
    `LQ_SZ_BYTEU, `LQ_SZ_HALFU, `LQ_SZ_HALF_NAN};

  logic                  i_clk = 1'b0;
  logic                  i_reset_n;
  logic                  i_bypass_disable;
  logic                  i_alloc;
  lq_info_s              i_alloc_info;
  lq_addr_wr_s           i_addr_wr;
  lq_exec_wr_s           i_exec_wr;
  lq_ret_s               i_ret;
  logic                  i_rden;
  logic [`LQ_ID_W-1:0]   o_next_id;
  logic [`LQ_ID_W-1:0]   o_head_id;
  logic                  o_data_ready;
  logic [`LQ_DATA_W-1:0] o_rddata;
  logic [`LQ_EXC_W-1:0]  o_rdexc;
  lq_info_s              o_rdinfo;
  logic                  o_fwd_vld;
  logic [`LQ_ID_W-1:0]   o_fwd_id;
  logic [`LQ_DATA_W-1:0] o_fwd_data;
  logic                  o_full;
  logic                  o_empty;

  model_entry_s          model [`LQ_DEPTH];
  logic [`LQ_ID_W-1:0]   order_q [$];  // ids in allocation order with the head first
  logic [`LQ_ID_W-1:0]   next_id_exp;
  logic [`LQ_ID_W-1:0]   ids [`LQ_DEPTH];
  string                 test_name;
  int                    errors;
  int                    test_first_error;
  int                    tests_run;
  int                    tests_failed;

  always #5 i_clk = ~i_clk;

  lq_top dut (.*);

  // lane select by offset and then extension by size code
  function automatic logic [31:0] expected_load(input logic [2:0] sz, input logic [3:0] ofs,
                                                input logic [31:0] raw);
    logic [31:0] b;
    logic [31:0] h;
    b = (raw >> (8 * ofs[1:0])) & 32'h0000_00ff;
    h = (raw >> (16 * ofs[1])) & 32'h0000_ffff;
    case (sz)
      `LQ_SZ_BYTE:     expected_load = b[7] ? (b | 32'hffff_ff00) : b;
      `LQ_SZ_HALF:     expected_load = h[15] ? (h | 32'hffff_0000) : h;
      `LQ_SZ_BYTEU:    expected_load = b;
      `LQ_SZ_HALFU:    expected_load = h;
      `LQ_SZ_HALF_NAN: expected_load = h | 32'hffff_0000;
      default:         expected_load = raw;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("test %s stopped: %s", test_name, why);
    $display("Simulation failed");
    $finish;
  endtask

  // all strobes go back to idle on the falling edge
  task automatic step();
    @(negedge i_clk);
    i_alloc   = 1'b0;
    i_addr_wr = '0;
    i_exec_wr = '0;
    i_ret     = '0;
    i_rden    = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name        = name;
    test_first_error = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_first_error) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_first_error);
    end
  endtask

  // loads get their address phase in the allocation cycle
  task automatic alloc_entry(input logic load, input logic [2:0] sz, output logic [2:0] id);
    step();
    id = next_id_exp;
    check_value("next id", 32'(id), 32'(o_next_id));
    check_value("full before alloc", 32'h0, 32'(o_full));
    i_alloc           = 1'b1;
    i_alloc_info.load = load;
    i_alloc_info.rd   = 5'($urandom);
    model[id]         = '0;
    model[id].info    = i_alloc_info;
    if (load) begin
      i_addr_wr.valid    = 1'b1;
      i_addr_wr.id       = id;
      i_addr_wr.attr.sz  = sz;
      i_addr_wr.attr.ofs = 4'($urandom);
      model[id].sz       = sz;
      model[id].ofs      = i_addr_wr.attr.ofs;
    end
    order_q.push_back(id);
    next_id_exp++;
    #1;
  endtask

  task automatic exec_write(input logic [2:0] id, input logic [31:0] data, input logic [4:0] exc);
    step();
    i_exec_wr       = '{valid: 1'b1, id: id, data: data, exc: exc};
    model[id].data  = data;
    model[id].exc   = exc;
    model[id].ready = 1'b1;
    #1;
  endtask

  // drives one return cycle and checks the forward in that cycle
  task automatic mem_return(input logic [2:0] id, input logic [31:0] raw, input logic cancel);
    logic [31:0] value;
    logic        fwd_exp;
    value   = expected_load(model[id].sz, model[id].ofs, raw);
    fwd_exp = (order_q.size() > 0) && (order_q[0] == id) && !cancel;
    step();
    i_ret = '{valid: 1'b1, cancel: cancel, id: id, data: raw};
    #1;
    check_value("forward valid", 32'(fwd_exp), 32'(o_fwd_vld));
    if (fwd_exp) begin
      check_value("forward id", 32'(id), 32'(o_fwd_id));
      check_value("forward data", value, o_fwd_data);
    end
    if (!cancel) begin
      model[id].data  = value;
      model[id].ready = 1'b1;
    end
  endtask

  task automatic retire_head(input logic now);
    model_entry_s head_exp;
    int           waited;
    waited = 0;
    if (!now) begin
      step();
      #1;
    end
    while (!o_data_ready && waited < 16) begin
      step();
      #1;
      waited++;
    end
    if (!o_data_ready) begin
      abort_run("head entry never became ready to retire");
    end else begin
      head_exp = model[order_q[0]];
      check_value("head id", 32'(order_q[0]), 32'(o_head_id));
      check_value("read info", 32'(head_exp.info), 32'(o_rdinfo));
      check_value("read data", head_exp.data, o_rddata);
      check_value("read flags", head_exp.info.load ? 32'h0 : 32'(head_exp.exc), 32'(o_rdexc));
      i_rden = 1'b1;
      void'(order_q.pop_front());
    end
  endtask

  task automatic drain();
    while (order_q.size() > 0) begin
      retire_head(1'b0);
    end
  endtask

  initial begin
    int n;
    void'($urandom(17));
    i_reset_n        = 1'b0;
    i_bypass_disable = 1'b1;
    i_alloc          = 1'b0;
    i_alloc_info     = '0;
    i_addr_wr        = '0;
    i_exec_wr        = '0;
    i_ret            = '0;
    i_rden           = 1'b0;
    next_id_exp      = '0;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (3) @(posedge i_clk);
    step();
    i_reset_n = 1'b1;
    #1;

    begin_test("ordering");
    check_value("full ready fwd empty", 32'h1, 32'({o_full, o_data_ready, o_fwd_vld, o_empty}));
    for (int i = 0; i < `LQ_DEPTH; i++) alloc_entry(1'b0, 3'd0, ids[i]);
    step();
    #1;
    check_value("full empty when loaded", 32'h2, 32'({o_full, o_empty}));
    for (int i = 0; i < `LQ_DEPTH; i++) exec_write(ids[i], $urandom, 5'($urandom));
    drain();
    step();
    #1;
    check_value("full empty when drained", 32'h1, 32'({o_full, o_empty}));
    end_test();

    begin_test("execute");
    for (int r = 0; r < 4; r++) begin
      n = $urandom_range(`LQ_DEPTH, 1);
      for (int i = 0; i < n; i++) alloc_entry(1'b0, 3'd0, ids[i]);
      for (int i = n - 1; i >= 0; i--) exec_write(ids[i], $urandom, 5'($urandom));
      drain();
    end
    end_test();

    begin_test("alignment");  // bypass still off so every return is stored
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 6; k++) alloc_entry(1'b1, sz_codes[k], ids[k]);
      for (int k = 5; k >= 0; k--) mem_return(ids[k], $urandom, 1'b0);
      drain();
    end
    end_test();

    begin_test("bypass");
    for (int r = 0; r < 6; r++) begin
      step();
      i_bypass_disable = r[0];  // odd rounds store the return instead
      alloc_entry(1'b1, sz_codes[r], ids[0]);
      mem_return(ids[0], $urandom, 1'b0);
      check_value("ready in return cycle", 32'(!r[0]), 32'(o_data_ready));
      if (r[0]) begin
        step();
        #1;
        check_value("ready after stored return", 32'h1, 32'(o_data_ready));
      end
      retire_head(1'b1);
    end
    end_test();

    begin_test("cancel");
    for (int r = 0; r < 4; r++) begin
      step();
      i_bypass_disable = r[0];
      alloc_entry(1'b1, sz_codes[$urandom_range(5, 0)], ids[0]);
      mem_return(ids[0], $urandom, 1'b1);
      check_value("ready in cancel cycle", 32'(model[ids[0]].ready), 32'(o_data_ready));
      step();
      #1;
      check_value("ready after cancel", 32'(model[ids[0]].ready), 32'(o_data_ready));
      mem_return(ids[0], $urandom, 1'b0);
      retire_head(1'b1);
    end
    end_test();

    begin_test("forward");
    step();
    i_bypass_disable = 1'b0;
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 3; k++) alloc_entry(1'b1, sz_codes[$urandom_range(5, 0)], ids[k]);
      mem_return(ids[2], $urandom, 1'b0);  // younger entries first give no forward
      mem_return(ids[1], $urandom, 1'b0);
      mem_return(ids[0], $urandom, 1'b0);
      retire_head(1'b1);
      drain();
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
source/lq_pkg.sv
source/lq_ptr_ctrl.sv
source/lq_entry_store.sv
source/lq_load_align.sv
source/lq_head_select.sv
source/lq_top.sv
bench/lq_top_assert.sv
bench/tb_lq_top.sv

/* Makefile */
TOP := tb_lq_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation completed successfully$$" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/10ps -f filelist.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
